// File: run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -j 0 \
  --top-module tb_uart_bridge -f uart_bridge.f --Mdir obj_dir &&
  sim_out="$(./obj_dir/Vtb_uart_bridge)" &&
  echo "$sim_out" &&
  grep -qx "=== PASS ===" <<< "$sim_out" &&
  echo "simulation passed" ||
  { echo "simulation did not pass"; exit 1; }

// File: tb/tb_uart_bridge.sv
`include "uart_bridge_macros.svh"

module tb_uart_bridge;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int BIT_CYCLES   = `UART_CLKS_PER_BIT;
  localparam int FRAME_CYCLES = `UART_FRAME_BITS * `UART_CLKS_PER_BIT;
  localparam int WAIT_BOUND   = 2 * FRAME_CYCLES + 64;
  localparam int NUM_CMDS     = 11;
  localparam int CYCLE_LIMIT  = NUM_CMDS * (3 * FRAME_CYCLES + 64);

  logic                   clk;
  logic                   rst_n;
  uart_bridge_pkg::cmd_t  cmd_in;
  logic                   cmd_vld;
  logic                   cmd_rdy;
  logic                   rx;
  logic                   tx;
  uart_bridge_pkg::read_t read_data;
  logic                   read_rdy;

  integer                 seed;
  int                     value_errors = 0;
  int                     protocol_errors = 0;
  int                     cycle_cnt = 0;
  int                     read_pulses = 0;
  uart_bridge_pkg::read_t last_read;
  logic                   rdy_at_read;
  uart_bridge_pkg::byte_t frame_bytes[$];
  logic                   frame_par_ok[$];
  logic                   frame_stop_ok[$];

  uart_bridge u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic check_byte(input uart_bridge_pkg::byte_t got,
                            input uart_bridge_pkg::byte_t exp, input string what);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s got %02h expected %02h", $time, what, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_read(input uart_bridge_pkg::read_t got,
                            input uart_bridge_pkg::read_t exp, input string what);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s got %03h expected %03h", $time, what, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s got %b expected %b", $time, what, got, exp);
      value_errors++;
    end
  endtask

  // remote side of tx sampled mid-bit on the falling clock edge
  task automatic capture_frame(output uart_bridge_pkg::byte_t data,
                               output logic par_ok, output logic stop_ok);
    logic [`UART_FRAME_BITS-1:0] bits;
    @(negedge clk);
    while (tx !== 1'b0) @(negedge clk);
    repeat (BIT_CYCLES / 2) @(negedge clk);
    bits[0] = tx;
    for (int i = 1; i < `UART_FRAME_BITS; i++) begin
      repeat (BIT_CYCLES) @(negedge clk);
      bits[i] = tx;
    end
    data    = bits[8:1];
    // data plus parity must hold an odd count of ones
    par_ok  = ^bits[9:1];
    stop_ok = bits[10];
  endtask

  // remote answer on rx then one idle bit
  task automatic send_frame(input uart_bridge_pkg::byte_t data,
                            input logic bad_par, input logic bad_stop);
    logic [`UART_FRAME_BITS-1:0] bits;
    bits = {~bad_stop, (~^data) ^ bad_par, data, 1'b0};
    @(posedge clk);
    for (int i = 0; i < `UART_FRAME_BITS; i++) begin
      rx <= bits[i];
      repeat (BIT_CYCLES) @(posedge clk);
    end
    rx <= 1'b1;
    repeat (BIT_CYCLES) @(posedge clk);
  endtask

  task automatic reset_dut();
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
  endtask

  task automatic issue_cmd(input uart_bridge_pkg::cmd_t cmd);
    int n;
    n = 0;
    @(posedge clk);
    cmd_in  <= cmd;
    cmd_vld <= 1'b1;
    @(negedge clk);
    while (!cmd_rdy && n < WAIT_BOUND) begin
      @(negedge clk);
      n++;
    end
    if (!cmd_rdy) begin
      $display("%0t: cmd_rdy never rose to take command %04h", $time, cmd);
      protocol_errors++;
    end
    // accepted on this edge
    @(posedge clk);
    cmd_vld <= 1'b0;
  endtask

  task automatic wait_cmd_done();
    int n;
    n = 0;
    @(negedge clk);
    while (!cmd_rdy && n < WAIT_BOUND) begin
      @(negedge clk);
      n++;
    end
    if (!cmd_rdy) begin
      $display("%0t: command did not finish within %0d cycles", $time, WAIT_BOUND);
      protocol_errors++;
    end
  endtask

  task automatic wait_frames(input int count, input string what);
    int n;
    n = 0;
    while (frame_bytes.size() < count && n < WAIT_BOUND) begin
      @(posedge clk);
      n++;
    end
    if (frame_bytes.size() < count) begin
      $display("%0t: %s is missing a frame on tx", $time, what);
      protocol_errors++;
    end
  endtask

  task automatic wait_read(input int r0);
    int n;
    n = 0;
    while (read_pulses == r0 && n < WAIT_BOUND) begin
      @(posedge clk);
      n++;
    end
    if (read_pulses == r0) begin
      $display("%0t: read_rdy did not pulse within %0d cycles", $time, WAIT_BOUND);
      protocol_errors++;
    end
  endtask

  task automatic check_frame_count(input int exp, input string what);
    if (frame_bytes.size() != exp) begin
      $display("%0t: %s gave %0d frames on tx instead of %0d",
               $time, what, frame_bytes.size(), exp);
      protocol_errors++;
    end
  endtask

  task automatic check_frame(input int idx, input uart_bridge_pkg::byte_t exp,
                             input string what);
    check_byte(frame_bytes[idx], exp, what);
    check_bit(frame_par_ok[idx], 1'b1, {what, " parity"});
    check_bit(frame_stop_ok[idx], 1'b1, {what, " stop bit"});
  endtask

  task automatic clear_frames();
    frame_bytes.delete();
    frame_par_ok.delete();
    frame_stop_ok.delete();
  endtask

  task automatic reset_state_test();
    @(negedge clk);
    check_bit(tx, 1'b1, "tx after reset");
    check_bit(cmd_rdy, 1'b1, "cmd_rdy after reset");
    check_bit(read_rdy, 1'b0, "read_rdy after reset");
  endtask

  task automatic write_cmd_test(input uart_bridge_pkg::cmd_t cmd);
    int r0;
    r0 = read_pulses;
    clear_frames();
    issue_cmd(cmd);
    wait_frames(2, "write command");
    wait_cmd_done();
    check_frame_count(2, "write command");
    if (frame_bytes.size() == 2) begin
      check_frame(0, cmd[`UART_CMD_WIDTH-1 -: 8], "write high byte");
      check_frame(1, cmd[7:0], "write low byte");
    end
    check_bit(read_pulses == r0, 1'b1, "no read_rdy on write");
  endtask

  task automatic read_cmd_test(input uart_bridge_pkg::cmd_t cmd,
                               input uart_bridge_pkg::byte_t answer,
                               input logic bad_par, input logic bad_stop);
    int r0;
    uart_bridge_pkg::read_t exp;
    exp = {bad_par | bad_stop, answer};
    r0  = read_pulses;
    clear_frames();
    issue_cmd(cmd);
    wait_frames(1, "read command");
    send_frame(answer, bad_par, bad_stop);
    wait_read(r0);
    check_frame_count(1, "read command");
    if (frame_bytes.size() == 1) begin
      check_frame(0, cmd[`UART_CMD_WIDTH-1 -: 8], "read high byte");
    end
    if (read_pulses == r0 + 1) begin
      check_read(last_read, exp, "read_data");
      check_bit(rdy_at_read, 1'b1, "cmd_rdy with read_rdy");
    end else if (read_pulses > r0 + 1) begin
      $display("%0t: read_rdy pulsed %0d times for one read", $time, read_pulses - r0);
      protocol_errors++;
    end
  endtask

  task automatic held_cmd_test(input uart_bridge_pkg::cmd_t first,
                               input uart_bridge_pkg::cmd_t ignored);
    int r0;
    clear_frames();
    issue_cmd(first);
    @(posedge clk);
    // second request while the bridge is still busy
    cmd_in  <= ignored;
    cmd_vld <= 1'b1;
    repeat (4) @(posedge clk);
    cmd_vld <= 1'b0;
    cmd_in  <= first;
    wait_frames(2, "held write");
    wait_cmd_done();
    // long enough for a third frame to be captured if one starts
    repeat (FRAME_CYCLES + 2 * BIT_CYCLES) @(posedge clk);
    check_frame_count(2, "held write");
    if (frame_bytes.size() == 2) begin
      check_frame(0, first[`UART_CMD_WIDTH-1 -: 8], "held high byte");
      check_frame(1, first[7:0], "held low byte");
    end
    check_bit(cmd_rdy, 1'b1, "cmd_rdy after held write");
    // stray frame while no read is pending
    r0 = read_pulses;
    send_frame(8'h5a, 1'b0, 1'b0);
    repeat (4) @(posedge clk);
    check_bit(read_pulses == r0, 1'b1, "no read_rdy for stray rx frame");
    check_bit(cmd_rdy, 1'b1, "cmd_rdy after stray rx frame");
  endtask

  task automatic random_cmd_test(input int count);
    logic [31:0] rnd;
    uart_bridge_pkg::cmd_t cmd;
    uart_bridge_pkg::byte_t answer;
    for (int i = 0; i < count; i++) begin
      rnd    = $random(seed);
      cmd    = rnd[15:0];
      answer = rnd[23:16];
      if (cmd[`UART_CMD_WIDTH-1]) begin
        read_cmd_test(cmd, answer, 1'b0, 1'b0);
      end else begin
        write_cmd_test(cmd);
      end
    end
  endtask

  initial begin : frame_monitor
    uart_bridge_pkg::byte_t data;
    logic par_ok;
    logic stop_ok;
    @(posedge rst_n);
    forever begin
      capture_frame(data, par_ok, stop_ok);
      frame_bytes.push_back(data);
      frame_par_ok.push_back(par_ok);
      frame_stop_ok.push_back(stop_ok);
    end
  end

  // read_rdy is a single-cycle pulse
  always @(negedge clk) begin
    if (rst_n && read_rdy === 1'b1) begin
      read_pulses++;
      last_read   = read_data;
      rdy_at_read = cmd_rdy;
    end
  end

  initial begin : watchdog
    while (cycle_cnt < CYCLE_LIMIT) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout: the run did not end within %0d cycles", CYCLE_LIMIT);
    $display("=== FAIL ===");
    $finish;
  end

  initial begin : main
    seed    = 32'h92b;
    cmd_in  = '0;
    cmd_vld = 1'b0;
    rx      = 1'b1;
    rst_n   = 1'b0;
    reset_dut();
    reset_state_test();
    write_cmd_test(16'h2a5c);
    read_cmd_test(16'h93e1, 8'hc6, 1'b0, 1'b0);
    read_cmd_test(16'had00, 8'h3b, 1'b1, 1'b0);
    read_cmd_test(16'hce7f, 8'h71, 1'b0, 1'b1);
    held_cmd_test(16'h4f96, 16'h8733);
    random_cmd_test(6);
    repeat (4) @(posedge clk);
    $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
    if (value_errors + protocol_errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: uart_bridge.f
+incdir+verilog
verilog/uart_bridge_pkg.sv
verilog/uart_tx_frame.sv
verilog/uart_rx_frame.sv
verilog/uart_cmd_ctrl.sv
verilog/uart_bridge.sv
tb/tb_uart_bridge.sv

// File: verilog/uart_bridge.sv
module uart_bridge (
  input  logic                   clk,
  input  logic                   rst_n,
  input  uart_bridge_pkg::cmd_t  cmd_in,
  input  logic                   cmd_vld,
  output logic                   cmd_rdy,
  input  logic                   rx,
  output logic                   tx,
  output uart_bridge_pkg::read_t read_data,
  output logic                   read_rdy
);

  logic                   tx_start;
  uart_bridge_pkg::byte_t tx_byte;
  logic                   tx_busy;
  logic                   rx_vld;
  uart_bridge_pkg::byte_t rx_byte;
  logic                   rx_err;

  uart_cmd_ctrl u_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .tx_start  (tx_start),
    .tx_byte   (tx_byte),
    .tx_busy   (tx_busy),
    .rx_vld    (rx_vld),
    .rx_byte   (rx_byte),
    .rx_err    (rx_err),
    .read_data (read_data),
    .read_rdy  (read_rdy)
  );

  uart_tx_frame u_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx       (tx),
    .tx_busy  (tx_busy)
  );

  // answers from the remote device
  uart_rx_frame u_rx (
    .clk     (clk),
    .rst_n   (rst_n),
    .rx      (rx),
    .rx_vld  (rx_vld),
    .rx_byte (rx_byte),
    .rx_err  (rx_err)
  );

endmodule

// File: verilog/uart_bridge_macros.svh
`ifndef UART_BRIDGE_MACROS_SVH
`define UART_BRIDGE_MACROS_SVH

// clock cycles per serial bit, 50 MHz at 115200 baud
`define UART_CLKS_PER_BIT 434

// host command width
`define UART_CMD_WIDTH 16

// start + 8 data + parity + stop
`define UART_FRAME_BITS 11

`endif

// File: verilog/uart_bridge_pkg.sv
`include "uart_bridge_macros.svh"

package uart_bridge_pkg;

  // read flag, 7-bit address, write data
  typedef logic [`UART_CMD_WIDTH-1:0] cmd_t;

  typedef logic [7:0] byte_t;

  // error flag on top of the received byte
  typedef logic [8:0] read_t;

  typedef logic [15:0] baud_cnt_t;
  typedef logic [3:0]  bit_cnt_t;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SEND_HI,
    ST_SEND_LO,
    ST_WAIT_RESP
  } ctrl_state_t;

endpackage

// File: verilog/uart_cmd_ctrl.sv
`include "uart_bridge_macros.svh"

module uart_cmd_ctrl (
  input  logic                   clk,
  input  logic                   rst_n,
  input  uart_bridge_pkg::cmd_t  cmd_in,
  input  logic                   cmd_vld,
  output logic                   cmd_rdy,
  output logic                   tx_start,
  output uart_bridge_pkg::byte_t tx_byte,
  input  logic                   tx_busy,
  input  logic                   rx_vld,
  input  uart_bridge_pkg::byte_t rx_byte,
  input  logic                   rx_err,
  output uart_bridge_pkg::read_t read_data,
  output logic                   read_rdy
);

  uart_bridge_pkg::ctrl_state_t state_q;
  uart_bridge_pkg::cmd_t        cmd_q;
  logic                         sent_q;
  logic                         accept;
  logic                         is_read;
  logic                         tx_done;
  logic                         hi_go;
  logic                         lo_go;
  logic                         resp_hit;

  assign accept  = (state_q == uart_bridge_pkg::ST_IDLE) && cmd_rdy && cmd_vld;
  assign is_read = cmd_q[`UART_CMD_WIDTH-1];

  // start pulse already seen by the transmitter and its frame finished
  assign tx_done = !tx_start && !tx_busy;

  assign hi_go    = (state_q == uart_bridge_pkg::ST_SEND_HI) && !sent_q && !tx_busy;
  // low byte is queued as the high byte frame ends
  assign lo_go    = (state_q == uart_bridge_pkg::ST_SEND_HI) && sent_q && tx_done && !is_read;
  assign resp_hit = (state_q == uart_bridge_pkg::ST_WAIT_RESP) && rx_vld;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q  <= uart_bridge_pkg::ST_IDLE;
      cmd_rdy  <= 1'b1;
      tx_start <= 1'b0;
      sent_q   <= 1'b0;
      read_rdy <= 1'b0;
    end else begin
      tx_start <= hi_go || lo_go;
      read_rdy <= resp_hit;
      case (state_q)
        uart_bridge_pkg::ST_IDLE: begin
          // one recovery cycle after a write
          if (!cmd_rdy) begin
            cmd_rdy <= 1'b1;
          end else if (cmd_vld) begin
            cmd_rdy <= 1'b0;
            sent_q  <= 1'b0;
            state_q <= uart_bridge_pkg::ST_SEND_HI;
          end
        end
        uart_bridge_pkg::ST_SEND_HI: begin
          if (hi_go) begin
            sent_q <= 1'b1;
          end else if (sent_q && tx_done) begin
            state_q <= is_read ? uart_bridge_pkg::ST_WAIT_RESP : uart_bridge_pkg::ST_SEND_LO;
          end
        end
        uart_bridge_pkg::ST_SEND_LO: begin
          if (tx_done) begin
            state_q <= uart_bridge_pkg::ST_IDLE;
          end
        end
        uart_bridge_pkg::ST_WAIT_RESP: begin
          // no timeout, remote must answer
          if (rx_vld) begin
            cmd_rdy <= 1'b1;
            state_q <= uart_bridge_pkg::ST_IDLE;
          end
        end
        default: begin
          state_q <= uart_bridge_pkg::ST_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_q <= cmd_in;
    end
    if (hi_go) begin
      tx_byte <= cmd_q[`UART_CMD_WIDTH-1 -: 8];
    end else if (lo_go) begin
      tx_byte <= cmd_q[7:0];
    end
    if (resp_hit) begin
      read_data <= {rx_err, rx_byte};
    end
  end

endmodule

// File: verilog/uart_rx_frame.sv
`include "uart_bridge_macros.svh"

module uart_rx_frame (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   rx,
  output logic                   rx_vld,
  output uart_bridge_pkg::byte_t rx_byte,
  output logic                   rx_err
);

  localparam uart_bridge_pkg::baud_cnt_t BAUD_LAST =
    uart_bridge_pkg::baud_cnt_t'(`UART_CLKS_PER_BIT - 1);
  localparam uart_bridge_pkg::baud_cnt_t BAUD_HALF =
    uart_bridge_pkg::baud_cnt_t'(`UART_CLKS_PER_BIT / 2 - 1);
  localparam uart_bridge_pkg::bit_cnt_t BIT_PARITY =
    uart_bridge_pkg::bit_cnt_t'(`UART_FRAME_BITS - 2);
  localparam uart_bridge_pkg::bit_cnt_t BIT_STOP =
    uart_bridge_pkg::bit_cnt_t'(`UART_FRAME_BITS - 1);

  logic                       rx_s1;
  logic                       rx_s2;
  logic                       rx_prev;
  logic                       active_q;
  uart_bridge_pkg::baud_cnt_t baud_cnt_q;
  uart_bridge_pkg::bit_cnt_t  bit_cnt_q;
  uart_bridge_pkg::byte_t     shift_q;
  logic                       parity_q;
  logic                       fall;
  logic                       start_chk;
  logic                       sample;

  // two-flop synchronizer plus one more stage for edge detect
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_s1   <= 1'b1;
      rx_s2   <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_s1   <= rx;
      rx_s2   <= rx_s1;
      rx_prev <= rx_s2;
    end
  end

  assign fall      = rx_prev && !rx_s2;
  assign start_chk = active_q && (bit_cnt_q == '0) && (baud_cnt_q == BAUD_HALF);
  assign sample    = active_q && (bit_cnt_q != '0) && (baud_cnt_q == BAUD_LAST);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active_q   <= 1'b0;
      baud_cnt_q <= '0;
      bit_cnt_q  <= '0;
      rx_vld     <= 1'b0;
    end else begin
      rx_vld <= 1'b0;
      if (!active_q) begin
        if (fall) begin
          active_q   <= 1'b1;
          baud_cnt_q <= '0;
          bit_cnt_q  <= '0;
        end
      end else if (start_chk) begin
        baud_cnt_q <= '0;
        // line back high at mid start, treat as a glitch
        if (rx_s2) begin
          active_q <= 1'b0;
        end else begin
          bit_cnt_q <= bit_cnt_q + 1'b1;
        end
      end else if (sample) begin
        baud_cnt_q <= '0;
        if (bit_cnt_q == BIT_STOP) begin
          active_q <= 1'b0;
          rx_vld   <= 1'b1;
        end else begin
          bit_cnt_q <= bit_cnt_q + 1'b1;
        end
      end else begin
        baud_cnt_q <= baud_cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (sample) begin
      if (bit_cnt_q < BIT_PARITY) begin
        // data arrives lsb first
        shift_q <= {rx_s2, shift_q[7:1]};
      end else if (bit_cnt_q == BIT_PARITY) begin
        parity_q <= rx_s2;
      end else begin
        rx_byte <= shift_q;
        // even ones count or low stop bit
        rx_err  <= ~(^{shift_q, parity_q}) | ~rx_s2;
      end
    end
  end

endmodule

// File: verilog/uart_tx_frame.sv
`include "uart_bridge_macros.svh"

module uart_tx_frame (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   tx_start,
  input  uart_bridge_pkg::byte_t tx_byte,
  output logic                   tx,
  output logic                   tx_busy
);

  localparam uart_bridge_pkg::baud_cnt_t BAUD_LAST =
    uart_bridge_pkg::baud_cnt_t'(`UART_CLKS_PER_BIT - 1);
  localparam uart_bridge_pkg::bit_cnt_t BIT_LAST =
    uart_bridge_pkg::bit_cnt_t'(`UART_FRAME_BITS - 1);

  logic [`UART_FRAME_BITS-1:0] frame_q;
  uart_bridge_pkg::baud_cnt_t  baud_cnt_q;
  uart_bridge_pkg::bit_cnt_t   bit_cnt_q;
  logic                        busy_q;
  logic                        parity;
  logic                        bit_end;

  // odd parity, byte plus parity has an odd count of ones
  assign parity  = ~^tx_byte;
  assign bit_end = (baud_cnt_q == BAUD_LAST);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      frame_q    <= '1;
      baud_cnt_q <= '0;
      bit_cnt_q  <= '0;
      busy_q     <= 1'b0;
    end else if (tx_start && !busy_q) begin
      // lsb goes out first, start bit sits at bit 0
      frame_q    <= {1'b1, parity, tx_byte, 1'b0};
      baud_cnt_q <= '0;
      bit_cnt_q  <= '0;
      busy_q     <= 1'b1;
    end else if (busy_q) begin
      if (bit_end) begin
        baud_cnt_q <= '0;
        if (bit_cnt_q == BIT_LAST) begin
          // stop bit done, line stays high
          busy_q <= 1'b0;
        end else begin
          bit_cnt_q <= bit_cnt_q + 1'b1;
          frame_q   <= {1'b1, frame_q[`UART_FRAME_BITS-1:1]};
        end
      end else begin
        baud_cnt_q <= baud_cnt_q + 1'b1;
      end
    end
  end

  // idle level is high through the all-ones fill
  assign tx      = frame_q[0];
  assign tx_busy = busy_q;

endmodule
